//--- list.f
source/eth_rx_pkg.sv
source/eth_rx_crc.sv
source/eth_rx_mii.sv
source/eth_rx_buffer.sv
source/eth_rx_regs.sv
source/eth_rx_top.sv
tests/eth_rx_properties.sv
tests/eth_rx_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= eth_rx_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= list.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= ALL TESTS PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) $(RUN_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/eth_rx_tb.sv
`timescale 1ns/1ns

module eth_rx_tb;

   localparam int          RESET_CYCLES = 10;
   localparam int          APB_TIMEOUT  = 20;
   localparam int          POLL_LIMIT   = 40;
   localparam int          GAP_CYCLES   = 12;
   localparam logic [47:0] OTHER_MAC    = 48'h02_00_5e_10_20_31;
   localparam logic [47:0] SOURCE_MAC   = 48'h02_aa_bb_cc_dd_ee;

   logic                   RX_CLK;
   logic                   ETH_PHY_RESETN;
   eth_rx_pkg::nibble_t    rx_data;
   logic                   rx_dv;
   logic                   psel;
   logic                   penable;
   logic                   pwrite;
   eth_rx_pkg::apb_addr_t  paddr;
   eth_rx_pkg::word_t      pwdata;
   eth_rx_pkg::word_t      prdata;
   logic                   pready;
   logic                   pslverr;

   logic [31:0] rng;
   logic [7:0]  tx_frame[$];
   logic [7:0]  exp_frame[$];
   logic [31:0] rd_data;
   logic        rd_err;
   int          errors;
   int          checks;
   int          tests;
   int          failed_tests;
   int          test_errors;

   eth_rx_top UUT (
      .RX_CLK         (RX_CLK),
      .ETH_PHY_RESETN (ETH_PHY_RESETN),
      .rx_data        (rx_data),
      .rx_dv          (rx_dv),
      .psel           (psel),
      .penable        (penable),
      .pwrite         (pwrite),
      .paddr          (paddr),
      .pwdata         (pwdata),
      .prdata         (prdata),
      .pready         (pready),
      .pslverr        (pslverr)
   );

   initial begin
      RX_CLK = 1'b0;
      forever #10 RX_CLK = ~RX_CLK;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x;
      y = y ^ (y << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Ethernet FCS, bit serial, LSB first, inverted at the end
   function automatic logic [31:0] fcs_of(input logic [7:0] data[$]);
      logic [31:0] crc;
      crc = 32'hffff_ffff;
      foreach (data[i]) begin
         for (int b = 0; b < 8; b++) begin
            if (crc[0] != data[i][b]) begin
               crc = (crc >> 1) ^ 32'hedb8_8320;
            end else begin
               crc = crc >> 1;
            end
         end
      end
      return ~crc;
   endfunction

   task automatic compare(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("error %s expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic pick_length(output int len);
      rng = xorshift(rng);
      len = 46 + int'(rng % 32'd155);
   endtask

   // Destination, source, type, random payload, then FCS low byte first
   task automatic build_frame(input logic [47:0] dst, input int payload_len);
      logic [31:0] fcs;
      tx_frame.delete();
      for (int i = 5; i >= 0; i--) begin
         tx_frame.push_back(dst[8*i +: 8]);
      end
      for (int i = 5; i >= 0; i--) begin
         tx_frame.push_back(SOURCE_MAC[8*i +: 8]);
      end
      tx_frame.push_back(8'h08);
      tx_frame.push_back(8'h00);
      for (int i = 0; i < payload_len; i++) begin
         rng = xorshift(rng);
         tx_frame.push_back(rng[7:0]);
      end
      fcs = fcs_of(tx_frame);
      for (int i = 0; i < 4; i++) begin
         tx_frame.push_back(fcs[8*i +: 8]);
      end
   endtask

   task automatic send_frame();
      for (int i = 0; i < 15; i++) begin
         @(posedge RX_CLK);
         rx_dv   <= 1'b1;
         rx_data <= eth_rx_pkg::PREAMBLE_NIBBLE;
      end
      @(posedge RX_CLK);
      rx_data <= eth_rx_pkg::SFD_NIBBLE;
      foreach (tx_frame[i]) begin
         @(posedge RX_CLK);
         rx_data <= tx_frame[i][3:0];
         @(posedge RX_CLK);
         rx_data <= tx_frame[i][7:4];
      end
      @(posedge RX_CLK);
      rx_dv   <= 1'b0;
      rx_data <= 4'h0;
      // Interframe gap
      repeat (GAP_CYCLES) @(posedge RX_CLK);
   endtask

   // Setup cycle, then access cycles until pready, sampled on the falling edge
   task automatic apb_access(input logic write, input eth_rx_pkg::apb_addr_t addr,
                             input logic [31:0] wdata);
      int   cycles;
      logic done;
      @(posedge RX_CLK);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= write;
      paddr   <= addr;
      pwdata  <= wdata;
      @(posedge RX_CLK);
      penable <= 1'b1;
      done    = 1'b0;
      cycles  = 0;
      rd_data = '0;
      rd_err  = 1'b0;
      while (!done && cycles < APB_TIMEOUT) begin
         @(negedge RX_CLK);
         if (pready) begin
            rd_data = prdata;
            rd_err  = pslverr;
            done    = 1'b1;
         end
         cycles++;
         @(posedge RX_CLK);
      end
      psel    <= 1'b0;
      penable <= 1'b0;
      if (!done) begin
         errors++;
         $display("APB transfer at address %h got no pready within %0d cycles",
                  addr, APB_TIMEOUT);
      end
   endtask

   task automatic apb_read(input eth_rx_pkg::apb_addr_t addr);
      apb_access(1'b0, addr, 32'h0);
   endtask

   task automatic apb_write(input eth_rx_pkg::apb_addr_t addr, input logic [31:0] data);
      apb_access(1'b1, addr, data);
   endtask

   task automatic wait_frame_valid();
      int polls;
      polls   = 0;
      rd_data = '0;
      while (rd_data[0] !== 1'b1 && polls < POLL_LIMIT) begin
         apb_read(eth_rx_pkg::REG_STATUS);
         polls++;
      end
      if (rd_data[0] !== 1'b1) begin
         errors++;
         $display("STATUS frame valid bit did not rise within %0d polls", POLL_LIMIT);
      end
   endtask

   // Status, size, FCS and every buffer word against exp_frame
   task automatic verify_frame(input logic crc_expected);
      int          n;
      logic [31:0] fcs;
      logic [31:0] word;
      logic [31:0] mask;
      n = exp_frame.size();
      apb_read(eth_rx_pkg::REG_STATUS);
      compare("STATUS.frame_valid", 32'd1, 32'(rd_data[0]));
      compare("STATUS.crc_good", 32'(crc_expected), 32'(rd_data[1]));
      compare("STATUS.dv_seen", 32'd1, 32'(rd_data[2]));
      apb_read(eth_rx_pkg::REG_RCV_SIZE);
      compare("RCV_SIZE", 32'(n), rd_data);
      fcs = {exp_frame[n-1], exp_frame[n-2], exp_frame[n-3], exp_frame[n-4]};
      apb_read(eth_rx_pkg::REG_FCS);
      compare("FCS", fcs, rd_data);
      for (int w = 0; 4*w < n; w++) begin
         word = '0;
         mask = '0;
         for (int l = 0; l < 4; l++) begin
            if (4*w + l < n) begin
               word[8*l +: 8] = exp_frame[4*w + l];
               mask[8*l +: 8] = 8'hff;
            end
         end
         apb_read(eth_rx_pkg::BUF_BASE + 12'(4*w));
         compare($sformatf("buffer word %0d", w), word, rd_data & mask);
      end
   endtask

   task automatic acknowledge();
      apb_write(eth_rx_pkg::REG_RCV_ACK, 32'h1);
   endtask

   task automatic start_test();
      test_errors = errors;
   endtask

   task automatic report_test(input string name);
      tests++;
      if (errors == test_errors) begin
         $display("test %0d %s: passed", tests, name);
      end else begin
         failed_tests++;
         $display("test %0d %s: failed with %0d errors", tests, name, errors - test_errors);
      end
   endtask

   initial begin
      int plen;
      ETH_PHY_RESETN = 1'b0;
      rx_data        = 4'h0;
      rx_dv          = 1'b0;
      psel           = 1'b0;
      penable        = 1'b0;
      pwrite         = 1'b0;
      paddr          = '0;
      pwdata         = '0;
      rng            = 32'heb75_2a52;
      errors         = 0;
      checks         = 0;
      tests          = 0;
      failed_tests   = 0;
      repeat (RESET_CYCLES) @(posedge RX_CLK);
      ETH_PHY_RESETN <= 1'b1;

      start_test();
      pick_length(plen);
      build_frame(eth_rx_pkg::STATION_MAC, plen);
      exp_frame = tx_frame;
      send_frame();
      wait_frame_valid();
      verify_frame(1'b1);
      acknowledge();
      report_test("station address frame");

      start_test();
      pick_length(plen);
      build_frame(eth_rx_pkg::BROADCAST_MAC, plen);
      exp_frame = tx_frame;
      send_frame();
      wait_frame_valid();
      verify_frame(1'b1);
      acknowledge();
      report_test("broadcast frame");

      start_test();
      pick_length(plen);
      build_frame(OTHER_MAC, plen);
      send_frame();
      apb_read(eth_rx_pkg::REG_STATUS);
      compare("STATUS.frame_valid", 32'd0, 32'(rd_data[0]));
      report_test("foreign address dropped");

      // Payload starts at byte 14
      start_test();
      pick_length(plen);
      build_frame(eth_rx_pkg::STATION_MAC, plen);
      tx_frame[20] = tx_frame[20] ^ 8'h01;
      exp_frame = tx_frame;
      send_frame();
      wait_frame_valid();
      verify_frame(1'b0);
      acknowledge();
      report_test("corrupted payload");

      start_test();
      pick_length(plen);
      build_frame(eth_rx_pkg::STATION_MAC, plen);
      exp_frame = tx_frame;
      send_frame();
      wait_frame_valid();
      build_frame(eth_rx_pkg::STATION_MAC, plen + 7);
      send_frame();
      verify_frame(1'b1);
      acknowledge();
      apb_read(eth_rx_pkg::REG_STATUS);
      compare("STATUS.frame_valid", 32'd0, 32'(rd_data[0]));
      pick_length(plen);
      build_frame(eth_rx_pkg::STATION_MAC, plen);
      exp_frame = tx_frame;
      send_frame();
      wait_frame_valid();
      verify_frame(1'b1);
      acknowledge();
      report_test("frame held until acknowledge");

      start_test();
      pick_length(plen);
      build_frame(eth_rx_pkg::STATION_MAC, plen);
      send_frame();
      wait_frame_valid();
      apb_write(eth_rx_pkg::REG_SOFTRST, 32'h1);
      apb_read(eth_rx_pkg::REG_STATUS);
      compare("STATUS.frame_valid", 32'd0, 32'(rd_data[0]));
      compare("STATUS.crc_good", 32'd0, 32'(rd_data[1]));
      apb_read(eth_rx_pkg::REG_RCV_SIZE);
      compare("RCV_SIZE", 32'd0, rd_data);
      report_test("soft reset");

      start_test();
      apb_read(eth_rx_pkg::REG_STATUS);
      compare("pslverr", 32'd0, 32'(rd_err));
      apb_read(12'h014);
      compare("pslverr", 32'd1, 32'(rd_err));
      apb_write(eth_rx_pkg::BUF_BASE, 32'h1234_5678);
      compare("pslverr", 32'd1, 32'(rd_err));
      report_test("slave errors");

      $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
               tests, failed_tests, checks, errors, UUT.u_props.assert_fails);
      if (errors == 0 && UUT.u_props.assert_fails == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- tests/eth_rx_properties.sv
`timescale 1ns/1ns

module eth_rx_properties (
   input logic                  RX_CLK,
   input logic                  ETH_PHY_RESETN,
   input logic                  psel,
   input logic                  penable,
   input logic                  pwrite,
   input eth_rx_pkg::apb_addr_t paddr,
   input logic                  pready,
   input logic                  frame_valid,
   input logic                  rcv_ack,
   input logic                  soft_rst,
   input logic                  buf_wr
);

   int pready_fails = 0;
   int hold_fails   = 0;
   int write_fails  = 0;
   int assert_fails;

   assign assert_fails = pready_fails + hold_fails + write_fails;

   // APB completes only in an access cycle, buffer reads one cycle late
   a_pready_access: assert property (@(posedge RX_CLK) disable iff (!ETH_PHY_RESETN)
      pready == (psel && penable && (pwrite || !paddr[11] || $past(psel && penable))))
   else begin
      pready_fails = pready_fails + 1;
      $error("pready does not follow the APB access and wait state timing");
   end

   // Held frame is released only by the host
   a_frame_hold: assert property (@(posedge RX_CLK) disable iff (!ETH_PHY_RESETN)
      (frame_valid && !rcv_ack && !soft_rst) |=> frame_valid)
   else begin
      hold_fails = hold_fails + 1;
      $error("frame_valid fell without rcv_ack or soft_rst");
   end

   a_no_write_in_hold: assert property (@(posedge RX_CLK) disable iff (!ETH_PHY_RESETN)
      !(buf_wr && frame_valid))
   else begin
      write_fails = write_fails + 1;
      $error("buffer written while a frame is held");
   end

endmodule

bind eth_rx_top eth_rx_properties u_props (
   .RX_CLK         (RX_CLK),
   .ETH_PHY_RESETN (ETH_PHY_RESETN),
   .psel           (psel),
   .penable        (penable),
   .pwrite         (pwrite),
   .paddr          (paddr),
   .pready         (pready),
   .frame_valid    (frame_valid),
   .rcv_ack        (rcv_ack),
   .soft_rst       (soft_rst),
   .buf_wr         (buf_wr)
);

//--- source/eth_rx_top.sv
`timescale 1ns/1ns

module eth_rx_top (
   input  logic                     RX_CLK,
   input  logic                     ETH_PHY_RESETN,
   input  eth_rx_pkg::nibble_t      rx_data,
   input  logic                     rx_dv,
   input  logic                     psel,
   input  logic                     penable,
   input  logic                     pwrite,
   input  eth_rx_pkg::apb_addr_t    paddr,
   input  eth_rx_pkg::word_t        pwdata,
   output eth_rx_pkg::word_t        prdata,
   output logic                     pready,
   output logic                     pslverr
);

   logic                   buf_wr;
   eth_rx_pkg::buf_addr_t  buf_waddr;
   logic [1:0]             buf_lane;
   eth_rx_pkg::byte_t      buf_wdata;
   logic                   buf_ren;
   eth_rx_pkg::buf_addr_t  buf_raddr;
   eth_rx_pkg::word_t      buf_rdata;
   logic                   crc_clear;
   logic                   crc_en;
   eth_rx_pkg::byte_t      crc_byte;
   logic                   crc_ok;
   logic                   frame_valid;
   eth_rx_pkg::frame_len_t frame_len;
   eth_rx_pkg::word_t      fcs;
   logic                   crc_good;
   logic                   rcv_ack;
   logic                   soft_rst;

   eth_rx_mii u_mii (
      .RX_CLK         (RX_CLK),
      .ETH_PHY_RESETN (ETH_PHY_RESETN),
      .rx_data        (rx_data),
      .rx_dv          (rx_dv),
      .rcv_ack        (rcv_ack),
      .soft_rst       (soft_rst),
      .crc_ok         (crc_ok),
      .buf_wr         (buf_wr),
      .buf_waddr      (buf_waddr),
      .buf_lane       (buf_lane),
      .buf_wdata      (buf_wdata),
      .crc_clear      (crc_clear),
      .crc_en         (crc_en),
      .crc_byte       (crc_byte),
      .frame_valid    (frame_valid),
      .frame_len      (frame_len),
      .fcs            (fcs),
      .crc_good       (crc_good)
   );

   // Only the residue check is needed on the receive side
   eth_rx_crc u_crc (
      .RX_CLK         (RX_CLK),
      .ETH_PHY_RESETN (ETH_PHY_RESETN),
      .crc_clear      (crc_clear),
      .crc_en         (crc_en),
      .crc_byte       (crc_byte),
      .crc_value      (),
      .crc_ok         (crc_ok)
   );

   eth_rx_buffer u_buffer (
      .RX_CLK         (RX_CLK),
      .buf_wr         (buf_wr),
      .buf_waddr      (buf_waddr),
      .buf_lane       (buf_lane),
      .buf_wdata      (buf_wdata),
      .buf_ren        (buf_ren),
      .buf_raddr      (buf_raddr),
      .buf_rdata      (buf_rdata)
   );

   eth_rx_regs u_regs (
      .RX_CLK         (RX_CLK),
      .ETH_PHY_RESETN (ETH_PHY_RESETN),
      .psel           (psel),
      .penable        (penable),
      .pwrite         (pwrite),
      .paddr          (paddr),
      .pwdata         (pwdata),
      .rx_dv          (rx_dv),
      .frame_valid    (frame_valid),
      .frame_len      (frame_len),
      .fcs            (fcs),
      .crc_good       (crc_good),
      .buf_rdata      (buf_rdata),
      .prdata         (prdata),
      .pready         (pready),
      .pslverr        (pslverr),
      .rcv_ack        (rcv_ack),
      .soft_rst       (soft_rst),
      .buf_ren        (buf_ren),
      .buf_raddr      (buf_raddr)
   );

endmodule

//--- source/eth_rx_regs.sv
`timescale 1ns/1ns

module eth_rx_regs (
   input  logic                     RX_CLK,
   input  logic                     ETH_PHY_RESETN,
   input  logic                     psel,
   input  logic                     penable,
   input  logic                     pwrite,
   input  eth_rx_pkg::apb_addr_t    paddr,
   input  eth_rx_pkg::word_t        pwdata,
   input  logic                     rx_dv,
   input  logic                     frame_valid,
   input  eth_rx_pkg::frame_len_t   frame_len,
   input  eth_rx_pkg::word_t        fcs,
   input  logic                     crc_good,
   input  eth_rx_pkg::word_t        buf_rdata,
   output eth_rx_pkg::word_t        prdata,
   output logic                     pready,
   output logic                     pslverr,
   output logic                     rcv_ack,
   output logic                     soft_rst,
   output logic                     buf_ren,
   output eth_rx_pkg::buf_addr_t    buf_raddr
);

   logic access;
   logic buf_sel;
   logic buf_read;
   logic buf_wait;
   logic reg_hit;
   logic reg_write;
   logic dv_seen;

   assign access   = psel && penable;
   assign buf_sel  = |(paddr & eth_rx_pkg::BUF_BASE);
   assign buf_read = buf_sel && !pwrite;
   assign reg_hit  = (paddr == eth_rx_pkg::REG_STATUS)   ||
                     (paddr == eth_rx_pkg::REG_RCV_SIZE) ||
                     (paddr == eth_rx_pkg::REG_RCV_ACK)  ||
                     (paddr == eth_rx_pkg::REG_FCS)      ||
                     (paddr == eth_rx_pkg::REG_SOFTRST);

   // Buffer reads wait one cycle for the RAM
   assign pready  = access && (!buf_read || buf_wait);
   assign pslverr = pready && (buf_sel ? pwrite : !reg_hit);

   assign buf_ren   = access && buf_read && !buf_wait;
   assign buf_raddr = paddr[10:2];

   // Write strobes, one cycle since register accesses have no wait state
   assign reg_write = access && pwrite && !buf_sel;
   assign rcv_ack   = reg_write && (paddr == eth_rx_pkg::REG_RCV_ACK) && pwdata[0];
   assign soft_rst  = reg_write && (paddr == eth_rx_pkg::REG_SOFTRST) && pwdata[0];

   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         buf_wait <= 1'b0;
      end else begin
         buf_wait <= buf_ren;
      end
   end

   // Sticky, only a PHY reset clears it
   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         dv_seen <= 1'b0;
      end else if (rx_dv) begin
         dv_seen <= 1'b1;
      end
   end

   always_comb begin
      prdata = '0;
      if (buf_sel) begin
         prdata = buf_rdata;
      end else begin
         case (paddr)
            eth_rx_pkg::REG_STATUS:   prdata = eth_rx_pkg::word_t'({dv_seen, crc_good, frame_valid});
            eth_rx_pkg::REG_RCV_SIZE: prdata = eth_rx_pkg::word_t'(frame_len);
            eth_rx_pkg::REG_FCS:      prdata = fcs;
            default:                  prdata = '0;
         endcase
      end
   end

endmodule

//--- source/eth_rx_buffer.sv
`timescale 1ns/1ns

module eth_rx_buffer (
   input  logic                    RX_CLK,
   input  logic                    buf_wr,
   input  eth_rx_pkg::buf_addr_t   buf_waddr,
   input  logic [1:0]              buf_lane,
   input  eth_rx_pkg::byte_t       buf_wdata,
   input  logic                    buf_ren,
   input  eth_rx_pkg::buf_addr_t   buf_raddr,
   output eth_rx_pkg::word_t       buf_rdata
);

   eth_rx_pkg::word_t mem [eth_rx_pkg::BUF_WORDS];

   // Receiver side, one byte lane per write
   always_ff @(posedge RX_CLK) begin
      if (buf_wr) begin
         mem[buf_waddr][8*buf_lane +: 8] <= buf_wdata;
      end
   end

   // Host side, registered word read
   always_ff @(posedge RX_CLK) begin
      if (buf_ren) begin
         buf_rdata <= mem[buf_raddr];
      end
   end

endmodule

//--- source/eth_rx_mii.sv
`timescale 1ns/1ns

module eth_rx_mii (
   input  logic                     RX_CLK,
   input  logic                     ETH_PHY_RESETN,
   input  eth_rx_pkg::nibble_t      rx_data,
   input  logic                     rx_dv,
   input  logic                     rcv_ack,
   input  logic                     soft_rst,
   input  logic                     crc_ok,
   output logic                     buf_wr,
   output eth_rx_pkg::buf_addr_t    buf_waddr,
   output logic [1:0]               buf_lane,
   output eth_rx_pkg::byte_t        buf_wdata,
   output logic                     crc_clear,
   output logic                     crc_en,
   output eth_rx_pkg::byte_t        crc_byte,
   output logic                     frame_valid,
   output eth_rx_pkg::frame_len_t   frame_len,
   output eth_rx_pkg::word_t        fcs,
   output logic                     crc_good
);

   eth_rx_pkg::rx_state_t  state;
   eth_rx_pkg::nibble_t    nib_lo;
   eth_rx_pkg::byte_t      rx_byte;
   eth_rx_pkg::frame_len_t byte_cnt;
   eth_rx_pkg::word_t      fcs_shift;
   logic                   high_phase;
   logic [2:0]             hdr_idx;
   logic                   match_station;
   logic                   match_bcast;
   logic                   station_hit;
   logic                   bcast_hit;
   logic                   byte_stb;
   logic                   room;
   logic                   frame_end;

   assign rx_byte   = {rx_data, nib_lo};
   assign byte_stb  = rx_dv && high_phase &&
                      (state == eth_rx_pkg::RX_HEADER || state == eth_rx_pkg::RX_PAYLOAD);
   assign room      = (byte_cnt != eth_rx_pkg::MAX_FRAME_BYTES);
   assign frame_end = (state == eth_rx_pkg::RX_PAYLOAD) && !rx_dv;

   // Running compare of destination byte hdr_idx against both addresses
   assign station_hit = match_station && (rx_byte ==
      eth_rx_pkg::STATION_MAC[8*(eth_rx_pkg::MAC_BYTES-1-hdr_idx) +: 8]);
   assign bcast_hit   = match_bcast && (rx_byte ==
      eth_rx_pkg::BROADCAST_MAC[8*(eth_rx_pkg::MAC_BYTES-1-hdr_idx) +: 8]);

   // CRC folds in the same edge the high nibble is sampled
   assign crc_clear   = (state == eth_rx_pkg::RX_PREAMBLE);
   assign crc_en      = byte_stb;
   assign crc_byte    = rx_byte;
   assign frame_valid = (state == eth_rx_pkg::RX_HOLD);

   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         state         <= eth_rx_pkg::RX_IDLE;
         high_phase    <= 1'b0;
         hdr_idx       <= '0;
         match_station <= 1'b1;
         match_bcast   <= 1'b1;
         byte_cnt      <= '0;
      end else if (soft_rst) begin
         state         <= eth_rx_pkg::RX_IDLE;
         high_phase    <= 1'b0;
         hdr_idx       <= '0;
         match_station <= 1'b1;
         match_bcast   <= 1'b1;
         byte_cnt      <= '0;
      end else begin
         case (state)
            eth_rx_pkg::RX_IDLE: begin
               if (rx_dv) begin
                  state <= eth_rx_pkg::RX_PREAMBLE;
               end
            end
            eth_rx_pkg::RX_PREAMBLE: begin
               high_phase    <= 1'b0;
               hdr_idx       <= '0;
               match_station <= 1'b1;
               match_bcast   <= 1'b1;
               byte_cnt      <= '0;
               if (!rx_dv) begin
                  state <= eth_rx_pkg::RX_IDLE;
               end else if (rx_data == eth_rx_pkg::SFD_NIBBLE) begin
                  state <= eth_rx_pkg::RX_HEADER;
               end else if (rx_data != eth_rx_pkg::PREAMBLE_NIBBLE) begin
                  // Joined mid-frame, wait for the line to go quiet
                  state <= eth_rx_pkg::RX_DROP;
               end
            end
            eth_rx_pkg::RX_HEADER: begin
               if (!rx_dv) begin
                  state <= eth_rx_pkg::RX_IDLE;
               end else if (high_phase) begin
                  match_station <= station_hit;
                  match_bcast   <= bcast_hit;
                  hdr_idx       <= hdr_idx + 3'd1;
                  if (!station_hit && !bcast_hit) begin
                     state <= eth_rx_pkg::RX_DROP;
                  end else if (hdr_idx == 3'(eth_rx_pkg::MAC_BYTES - 1)) begin
                     state <= eth_rx_pkg::RX_PAYLOAD;
                  end
               end
            end
            eth_rx_pkg::RX_PAYLOAD: begin
               if (!rx_dv) begin
                  state <= eth_rx_pkg::RX_HOLD;
               end
            end
            eth_rx_pkg::RX_DROP: begin
               if (!rx_dv) begin
                  state <= eth_rx_pkg::RX_IDLE;
               end
            end
            eth_rx_pkg::RX_HOLD: begin
               // rx_dv is ignored until the host acknowledges
               if (rcv_ack) begin
                  state <= eth_rx_pkg::RX_IDLE;
               end
            end
            default: begin
               state <= eth_rx_pkg::RX_IDLE;
            end
         endcase
         if (rx_dv && (state == eth_rx_pkg::RX_HEADER || state == eth_rx_pkg::RX_PAYLOAD)) begin
            high_phase <= !high_phase;
         end
         if (byte_stb && room) begin
            byte_cnt <= byte_cnt + 11'd1;
         end
      end
   end

   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         buf_wr    <= 1'b0;
         frame_len <= '0;
         fcs       <= '0;
         crc_good  <= 1'b0;
      end else if (soft_rst) begin
         buf_wr    <= 1'b0;
         frame_len <= '0;
         fcs       <= '0;
         crc_good  <= 1'b0;
      end else begin
         buf_wr <= byte_stb && room;
         if (frame_end) begin
            frame_len <= byte_cnt;
            fcs       <= fcs_shift;
            crc_good  <= crc_ok;
         end
      end
   end

   // Write payload and the trailing four bytes, oldest in bits 7:0
   always_ff @(posedge RX_CLK) begin
      if (rx_dv && !high_phase) begin
         nib_lo <= rx_data;
      end
      if (byte_stb) begin
         fcs_shift <= {rx_byte, fcs_shift[31:8]};
         buf_wdata <= rx_byte;
         buf_waddr <= byte_cnt[10:2];
         buf_lane  <= byte_cnt[1:0];
      end
   end

endmodule

//--- source/eth_rx_crc.sv
`timescale 1ns/1ns

module eth_rx_crc (
   input  logic                RX_CLK,
   input  logic                ETH_PHY_RESETN,
   input  logic                crc_clear,
   input  logic                crc_en,
   input  eth_rx_pkg::byte_t   crc_byte,
   output eth_rx_pkg::crc_t    crc_value,
   output logic                crc_ok
);

   eth_rx_pkg::crc_t crc_q;

   // One byte, least significant bit first
   function automatic eth_rx_pkg::crc_t crc_fold(input eth_rx_pkg::crc_t crc_in,
                                                 input eth_rx_pkg::byte_t data);
      eth_rx_pkg::crc_t c;
      c = crc_in;
      for (int i = 0; i < 8; i++) begin
         if (c[0] ^ data[i]) begin
            c = (c >> 1) ^ eth_rx_pkg::CRC_POLY;
         end else begin
            c = c >> 1;
         end
      end
      return c;
   endfunction

   always_ff @(posedge RX_CLK or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         crc_q <= '1;
      end else if (crc_clear) begin
         crc_q <= '1;
      end else if (crc_en) begin
         crc_q <= crc_fold(crc_q, crc_byte);
      end
   end

   assign crc_value = crc_q;
   assign crc_ok    = (crc_q == eth_rx_pkg::CRC_RESIDUE);

endmodule

//--- source/eth_rx_pkg.sv
package eth_rx_pkg;

   typedef logic [3:0]  nibble_t;
   typedef logic [7:0]  byte_t;
   typedef logic [31:0] word_t;
   typedef logic [11:0] apb_addr_t;
   typedef logic [10:0] frame_len_t;
   typedef logic [8:0]  buf_addr_t;
   typedef logic [31:0] crc_t;
   typedef logic [47:0] mac_addr_t;

   typedef enum logic [2:0] {
      RX_IDLE,
      RX_PREAMBLE,
      RX_HEADER,
      RX_PAYLOAD,
      RX_DROP,
      RX_HOLD
   } rx_state_t;

   // Locally administered station address, first wire byte is the MSB
   localparam mac_addr_t  STATION_MAC     = 48'h02_00_5e_10_20_30;
   localparam mac_addr_t  BROADCAST_MAC   = 48'hffff_ffff_ffff;
   localparam int         MAC_BYTES       = 6;

   localparam nibble_t    PREAMBLE_NIBBLE = 4'h5;
   localparam nibble_t    SFD_NIBBLE      = 4'hd;

   localparam crc_t       CRC_POLY        = 32'hedb8_8320;
   // Register value after a good frame with its FCS folded in
   localparam crc_t       CRC_RESIDUE     = 32'hdebb_20e3;

   localparam frame_len_t MAX_FRAME_BYTES = 11'd2047;
   localparam int         BUF_WORDS       = 512;

   // APB register map
   localparam apb_addr_t  REG_STATUS      = 12'h000;
   localparam apb_addr_t  REG_RCV_SIZE    = 12'h004;
   localparam apb_addr_t  REG_RCV_ACK     = 12'h008;
   localparam apb_addr_t  REG_FCS         = 12'h00c;
   localparam apb_addr_t  REG_SOFTRST     = 12'h010;
   localparam apb_addr_t  BUF_BASE        = 12'h800;

endpackage
